// ==== quiz_pkg.sv ====
package quiz_pkg;

  // answer codes 0..4 are choices and 5..7 count as invalid entries
  localparam int ANSWER_W = 3;
  localparam int HP_W     = 3;

  typedef logic [ANSWER_W-1:0] answer_t;
  typedef logic [HP_W-1:0]     hp_t;

  // highest valid answer code
  localparam answer_t ANSWER_LAST = answer_t'(4);

  // controller state codes
  typedef enum logic [3:0] {
    READY    = 4'd2,
    QUESTION = 4'd3,
    INPUT    = 4'd4,
    DRAW     = 4'd6,
    WRONG    = 4'd7,
    GOOD     = 4'd8,
    OUCH     = 4'd9,
    WIN      = 4'd10,
    LOSE     = 4'd11
  } game_state_e;

  // judge outcome of one decide
  typedef enum logic [2:0] {
    V_NONE  = 3'd0,
    V_WRONG = 3'd1,
    V_GOOD  = 3'd2,
    V_OUCH  = 3'd3,
    V_DRAW  = 3'd4
  } verdict_e;

  typedef struct packed {
    logic     valid;
    verdict_e verdict;
  } judge_result_s;

  // key and opponent answer of the current round
  typedef struct packed {
    answer_t key;
    answer_t opp_ans;
  } question_s;

  // knockout flags for each side
  typedef struct packed {
    logic player_out;
    logic opp_out;
  } hp_status_s;

endpackage

// ==== answer_judge.sv ====
`timescale 1ns/1ns

module answer_judge (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    decide,
  input  quiz_pkg::question_s     cur_question,
  input  quiz_pkg::answer_t       sel_q,
  output quiz_pkg::judge_result_s result
);

  quiz_pkg::verdict_e verdict_d;
  quiz_pkg::verdict_e verdict_q;
  logic               valid_q;
  logic               sel_invalid;
  logic               player_ok;
  logic               opp_ok;

  // codes above the last choice are entry mistakes
  assign sel_invalid = (sel_q > quiz_pkg::ANSWER_LAST);

  assign player_ok = (sel_q == cur_question.key);
  assign opp_ok    = (cur_question.opp_ans == cur_question.key);

  // judge rule where the first match wins
  always_comb begin
    if (sel_invalid) begin
      verdict_d = quiz_pkg::V_WRONG;
    end else if (player_ok && !opp_ok) begin
      verdict_d = quiz_pkg::V_GOOD;
    end else if (!player_ok && opp_ok) begin
      verdict_d = quiz_pkg::V_OUCH;
    end else begin
      // both right or both wrong
      verdict_d = quiz_pkg::V_DRAW;
    end
  end

  // valid lasts one cycle per decide
  always_ff @(posedge CLK) begin
    if (RST) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= decide;
    end
  end

  always_ff @(posedge CLK) begin
    if (decide) begin
      verdict_q <= verdict_d;
    end
  end

  assign result.valid   = valid_q;
  assign result.verdict = verdict_q;

endmodule

// ==== hp_tracker.sv ====
`timescale 1ns/1ns

module hp_tracker #(
  parameter int HP_MAX = 3
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  quiz_pkg::judge_result_s result,
  input  logic                    match_restore,
  output quiz_pkg::hp_t           player_hp,
  output quiz_pkg::hp_t           opp_hp,
  output quiz_pkg::hp_status_s    hp_status
);

  localparam quiz_pkg::hp_t HP_FULL = quiz_pkg::hp_t'(HP_MAX);

  logic hit_player;
  logic hit_opp;

  // a hit on an empty counter is dropped
  assign hit_opp    = result.valid && (result.verdict == quiz_pkg::V_GOOD) &&
                      (opp_hp != '0);
  assign hit_player = result.valid && (result.verdict == quiz_pkg::V_OUCH) &&
                      (player_hp != '0);

  always_ff @(posedge CLK) begin
    if (RST || match_restore) begin
      player_hp <= HP_FULL;
      opp_hp    <= HP_FULL;
    end else begin
      if (hit_player) begin
        player_hp <= player_hp - quiz_pkg::hp_t'(1);
      end
      if (hit_opp) begin
        opp_hp <= opp_hp - quiz_pkg::hp_t'(1);
      end
    end
  end

  // knockout seen straight from the counters
  assign hp_status.player_out = (player_hp == '0);
  assign hp_status.opp_out    = (opp_hp == '0);

endmodule

// ==== game_control.sv ====
`timescale 1ns/1ns

module game_control #(
  parameter int HOLD_CYCLES = 50_000_000
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  logic                    que,
  input  quiz_pkg::question_s     question,
  input  quiz_pkg::answer_t       sel,
  input  logic                    dec,
  input  logic                    clr,
  input  quiz_pkg::judge_result_s result,
  input  quiz_pkg::hp_status_s    hp_status,
  output quiz_pkg::game_state_e   state,
  output quiz_pkg::question_s     cur_question,
  output quiz_pkg::answer_t       sel_q,
  output logic                    decide,
  output logic                    match_restore
);

  localparam int HOLD_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;

  typedef logic [HOLD_W-1:0] hold_cnt_t;

  localparam hold_cnt_t HOLD_LAST = hold_cnt_t'(HOLD_CYCLES - 1);

  quiz_pkg::game_state_e state_nxt;
  hold_cnt_t             hold_cnt;
  logic                  in_result;
  logic                  hold_done;
  logic                  start_q;
  logic                  que_q;
  logic                  dec_q;
  logic                  clr_q;

  // input strobes sampled once and decoded by the state a cycle later
  always_ff @(posedge CLK) begin
    if (RST) begin
      start_q <= 1'b0;
      que_q   <= 1'b0;
      dec_q   <= 1'b0;
      clr_q   <= 1'b0;
    end else begin
      start_q <= start;
      que_q   <= que;
      dec_q   <= dec;
      clr_q   <= clr;
    end
  end

  assign in_result = (state == quiz_pkg::WRONG) || (state == quiz_pkg::GOOD) ||
                     (state == quiz_pkg::OUCH)  || (state == quiz_pkg::DRAW) ||
                     (state == quiz_pkg::WIN)   || (state == quiz_pkg::LOSE);

  assign hold_done = in_result && (hold_cnt == HOLD_LAST);

  always_comb begin
    state_nxt = state;
    case (state)
      quiz_pkg::READY: begin
        if (que_q && start_q) state_nxt = quiz_pkg::QUESTION;
      end
      quiz_pkg::QUESTION: begin
        if (que_q) state_nxt = quiz_pkg::INPUT;
      end
      quiz_pkg::INPUT: begin
        // a verdict in flight wins over a repeat request
        if (result.valid) begin
          case (result.verdict)
            quiz_pkg::V_WRONG: state_nxt = quiz_pkg::WRONG;
            quiz_pkg::V_GOOD:  state_nxt = quiz_pkg::GOOD;
            quiz_pkg::V_OUCH:  state_nxt = quiz_pkg::OUCH;
            default:           state_nxt = quiz_pkg::DRAW;
          endcase
        end else if (que_q) begin
          state_nxt = quiz_pkg::QUESTION;
        end
      end
      quiz_pkg::WRONG: begin
        if (hold_done) state_nxt = quiz_pkg::INPUT;
      end
      quiz_pkg::GOOD: begin
        if (hp_status.opp_out) state_nxt = quiz_pkg::WIN;
        else if (hold_done)    state_nxt = quiz_pkg::READY;
      end
      quiz_pkg::OUCH: begin
        if (hp_status.player_out) state_nxt = quiz_pkg::LOSE;
        else if (hold_done)       state_nxt = quiz_pkg::READY;
      end
      quiz_pkg::DRAW, quiz_pkg::WIN, quiz_pkg::LOSE: begin
        if (hold_done) state_nxt = quiz_pkg::READY;
      end
      default: state_nxt = quiz_pkg::READY;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      state <= quiz_pkg::READY;
    end else begin
      state <= state_nxt;
    end
  end

  // hold timer restarts on every state change
  always_ff @(posedge CLK) begin
    if (RST || !in_result || (state_nxt != state)) begin
      hold_cnt <= '0;
    end else begin
      hold_cnt <= hold_cnt + hold_cnt_t'(1);
    end
  end

  // round data captured on the que that leaves READY
  always_ff @(posedge CLK) begin
    if ((state == quiz_pkg::READY) && que && start) begin
      cur_question <= question;
    end
    if (state == quiz_pkg::INPUT) begin
      sel_q <= sel;
    end
  end

  // no new decide while a repeat or a verdict is pending
  assign decide = dec_q && !que_q && !result.valid && (state == quiz_pkg::INPUT);

  always_ff @(posedge CLK) begin
    if (RST) begin
      match_restore <= 1'b0;
    end else begin
      match_restore <= ((state == quiz_pkg::READY) && clr_q) ||
                       (((state == quiz_pkg::WIN) || (state == quiz_pkg::LOSE)) && hold_done);
    end
  end

endmodule

// ==== quiz_top.sv ====
`timescale 1ns/1ns

module quiz_top #(
  parameter int HOLD_CYCLES = 50_000_000,
  parameter int HP_MAX      = 3
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic                  que,
  input  quiz_pkg::question_s   question,
  input  quiz_pkg::answer_t     sel,
  input  logic                  dec,
  input  logic                  clr,
  output quiz_pkg::game_state_e state,
  output quiz_pkg::hp_t         player_hp,
  output quiz_pkg::hp_t         opp_hp
);

  quiz_pkg::question_s     cur_question;
  quiz_pkg::answer_t       sel_q;
  quiz_pkg::judge_result_s result;
  quiz_pkg::hp_status_s    hp_status;
  logic                    decide;
  logic                    match_restore;

  game_control #(
    .HOLD_CYCLES (HOLD_CYCLES)
  ) control_i (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .que           (que),
    .question      (question),
    .sel           (sel),
    .dec           (dec),
    .clr           (clr),
    .result        (result),
    .hp_status     (hp_status),
    .state         (state),
    .cur_question  (cur_question),
    .sel_q         (sel_q),
    .decide        (decide),
    .match_restore (match_restore)
  );

  answer_judge judge_i (
    .CLK          (CLK),
    .RST          (RST),
    .decide       (decide),
    .cur_question (cur_question),
    .sel_q        (sel_q),
    .result       (result)
  );

  hp_tracker #(
    .HP_MAX (HP_MAX)
  ) hp_i (
    .CLK           (CLK),
    .RST           (RST),
    .result        (result),
    .match_restore (match_restore),
    .player_hp     (player_hp),
    .opp_hp        (opp_hp),
    .hp_status     (hp_status)
  );

endmodule

// ==== quiz_asserts.sv ====
`timescale 1ns/1ns

module quiz_asserts #(
  parameter int HP_MAX = 3
) (
  input logic                    CLK,
  input logic                    RST,
  input quiz_pkg::game_state_e   state,
  input logic                    decide,
  input logic                    match_restore,
  input quiz_pkg::judge_result_s result,
  input quiz_pkg::hp_t           player_hp,
  input quiz_pkg::hp_t           opp_hp
);

  a_state_legal: assert property (@(posedge CLK) disable iff (RST)
    state inside {quiz_pkg::READY, quiz_pkg::QUESTION, quiz_pkg::INPUT, quiz_pkg::DRAW,
                  quiz_pkg::WRONG, quiz_pkg::GOOD, quiz_pkg::OUCH, quiz_pkg::WIN,
                  quiz_pkg::LOSE})
    else $error("state holds an illegal encoding");

  a_hp_max: assert property (@(posedge CLK) disable iff (RST)
    (player_hp <= quiz_pkg::hp_t'(HP_MAX)) && (opp_hp <= quiz_pkg::hp_t'(HP_MAX)))
    else $error("hit points above the match start value");

  // counters only go up through a restore
  a_hp_no_rise: assert property (@(posedge CLK) disable iff (RST)
    !$past(match_restore) |-> (player_hp <= $past(player_hp)) && (opp_hp <= $past(opp_hp)))
    else $error("hit points rose without a match restore");

  // the verdict follows a decide while the controller still waits in INPUT
  a_decide_verdict: assert property (@(posedge CLK) disable iff (RST)
    decide |=> result.valid && (state == quiz_pkg::INPUT))
    else $error("decide without a verdict in INPUT");

endmodule

bind quiz_top quiz_asserts #(.HP_MAX(HP_MAX)) asserts_i (
  .CLK(CLK), .RST(RST), .state(state), .decide(decide), .match_restore(match_restore),
  .result(result), .player_hp(player_hp), .opp_hp(opp_hp));

// ==== tb_quiz.sv ====
`timescale 1ns/1ns

module tb_quiz;

  localparam int HOLD   = 8;
  localparam int HP_MAX = 3;
  localparam int NROWS  = 10;
  localparam quiz_pkg::hp_t HP_FULL = quiz_pkg::hp_t'(HP_MAX);

  // key, opponent answer, first pick, retry pick, repeat que, clr in INPUT, clr after
  typedef struct packed {
    quiz_pkg::answer_t key;
    quiz_pkg::answer_t opp;
    quiz_pkg::answer_t sel;
    quiz_pkg::answer_t retry;
    logic              rep;
    logic              clr_in;
    logic              clr_after;
  } row_s;

  row_s rows [NROWS] = '{
    '{3'd1, 3'd2, 3'd1, 3'd0, 1'b0, 1'b0, 1'b1},
    '{3'd3, 3'd3, 3'd0, 3'd0, 1'b1, 1'b0, 1'b0},
    '{3'd2, 3'd2, 3'd2, 3'd0, 1'b0, 1'b0, 1'b0},
    '{3'd0, 3'd4, 3'd1, 3'd0, 1'b0, 1'b1, 1'b0},
    '{3'd4, 3'd1, 3'd6, 3'd4, 1'b0, 1'b0, 1'b0},
    '{3'd1, 3'd0, 3'd1, 3'd0, 1'b0, 1'b0, 1'b0},
    '{3'd2, 3'd3, 3'd2, 3'd0, 1'b0, 1'b0, 1'b0},
    '{3'd0, 3'd0, 3'd1, 3'd0, 1'b0, 1'b0, 1'b0},
    '{3'd3, 3'd3, 3'd5, 3'd2, 1'b0, 1'b0, 1'b0},
    '{3'd1, 3'd1, 3'd7, 3'd4, 1'b0, 1'b0, 1'b0}
  };

  logic                  CLK;
  logic                  RST;
  logic                  start, que, dec, clr;
  quiz_pkg::question_s   question;
  quiz_pkg::answer_t     sel;
  quiz_pkg::game_state_e state;
  quiz_pkg::hp_t         player_hp, opp_hp;
  quiz_pkg::hp_t         exp_player, exp_opp;

  quiz_top #(.HOLD_CYCLES(HOLD), .HP_MAX(HP_MAX)) dut_i (
    .CLK(CLK), .RST(RST), .start(start), .que(que), .question(question), .sel(sel),
    .dec(dec), .clr(clr), .state(state), .player_hp(player_hp), .opp_hp(opp_hp)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_state(input quiz_pkg::game_state_e exp, input string what);
    if (state !== exp) begin
      report_failure($sformatf("** Error at %0t ns: %s: state %s, expected %s",
                               $time, what, state.name(), exp.name()));
    end
  endtask

  task automatic check_hp(input quiz_pkg::hp_t got, input quiz_pkg::hp_t exp,
                          input string what);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t ns: %s: hp %0d, expected %0d",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_hp_pair(input string what);
    check_hp(player_hp, exp_player, {"player_hp ", what});
    check_hp(opp_hp, exp_opp, {"opp_hp ", what});
  endtask

  task automatic wait_state(input quiz_pkg::game_state_e exp);
    int n;
    n = 0;
    while ((state !== exp) && (n < 4 * HOLD + 20)) begin
      @(negedge CLK);
      n++;
    end
    if (state !== exp) begin
      report_failure($sformatf("state %s never arrived, still in %s",
                               exp.name(), state.name()));
    end
  endtask

  // result state on show for HOLD cycles before the next one
  task automatic hold_check(input quiz_pkg::game_state_e s, input quiz_pkg::game_state_e nxt);
    repeat (HOLD - 1) begin
      @(negedge CLK);
      check_state(s, "result hold");
    end
    @(negedge CLK);
    check_state(nxt, "after hold");
  endtask

  task automatic pulse_que();
    que = 1'b1;
    @(negedge CLK);
    que = 1'b0;
  endtask

  task automatic pulse_clr();
    clr = 1'b1;
    @(negedge CLK);
    clr = 1'b0;
  endtask

  task automatic decide_answer(input quiz_pkg::answer_t pick);
    sel = pick;
    dec = 1'b1;
    @(negedge CLK);
    dec = 1'b0;
  endtask

  // reference judge in rule order
  function automatic quiz_pkg::game_state_e expect_verdict(input row_s r,
                                                           input quiz_pkg::answer_t pick);
    logic player_ok;
    logic opp_ok;
    player_ok = (pick == r.key);
    opp_ok    = (r.opp == r.key);
    if (pick > 3'd4) return quiz_pkg::WRONG;
    if (player_ok && !opp_ok) return quiz_pkg::GOOD;
    if (!player_ok && opp_ok) return quiz_pkg::OUCH;
    return quiz_pkg::DRAW;
  endfunction

  task automatic play_round(input row_s r);
    quiz_pkg::game_state_e exp;
    quiz_pkg::answer_t     pick;
    start    = 1'b1;
    question = '{key: r.key, opp_ans: r.opp};
    pulse_que();
    wait_state(quiz_pkg::QUESTION);
    pulse_que();
    wait_state(quiz_pkg::INPUT);
    if (r.rep) begin
      // another question on the bus must not reach the running round
      question = '{key: r.sel, opp_ans: ~r.sel};
      pulse_que();
      wait_state(quiz_pkg::QUESTION);
      pulse_que();
      wait_state(quiz_pkg::INPUT);
    end
    if (r.clr_in) begin
      pulse_clr();
      repeat (3) @(negedge CLK);
      check_state(quiz_pkg::INPUT, "clr in INPUT");
      check_hp_pair("after clr in INPUT");
    end
    pick = r.sel;
    exp  = expect_verdict(r, pick);
    if (exp == quiz_pkg::WRONG) begin
      decide_answer(pick);
      wait_state(quiz_pkg::WRONG);
      hold_check(quiz_pkg::WRONG, quiz_pkg::INPUT);
      check_hp_pair("after invalid answer");
      pick = r.retry;
      exp  = expect_verdict(r, pick);
    end
    decide_answer(pick);
    wait_state(exp);
    if ((exp == quiz_pkg::GOOD) && (exp_opp != '0)) begin
      exp_opp = exp_opp - quiz_pkg::hp_t'(1);
    end
    if ((exp == quiz_pkg::OUCH) && (exp_player != '0)) begin
      exp_player = exp_player - quiz_pkg::hp_t'(1);
    end
    check_hp_pair("after verdict");
    if (((exp == quiz_pkg::GOOD) && (exp_opp == '0)) ||
        ((exp == quiz_pkg::OUCH) && (exp_player == '0))) begin
      @(negedge CLK);
      if (exp == quiz_pkg::GOOD) exp = quiz_pkg::WIN;
      else exp = quiz_pkg::LOSE;
      check_state(exp, "knockout");
      exp_player = HP_FULL;
      exp_opp    = HP_FULL;
    end
    hold_check(exp, quiz_pkg::READY);
    // restore lands one edge after leaving WIN or LOSE
    @(negedge CLK);
    check_hp_pair("at end of round");
    if (r.clr_after) begin
      pulse_clr();
      repeat (2) @(negedge CLK);
      exp_player = HP_FULL;
      exp_opp    = HP_FULL;
      check_hp_pair("after clr in READY");
    end
  endtask

  initial begin
    RST        = 1'b1;
    start      = 1'b0;
    que        = 1'b0;
    dec        = 1'b0;
    clr        = 1'b0;
    sel        = '0;
    question   = '0;
    exp_player = HP_FULL;
    exp_opp    = HP_FULL;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    check_state(quiz_pkg::READY, "after reset");
    check_hp_pair("after reset");
    // que without start stays in READY
    pulse_que();
    repeat (3) @(negedge CLK);
    check_state(quiz_pkg::READY, "que with start low");
    for (int i = 0; i < NROWS; i++) begin
      play_round(rows[i]);
    end
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #((NROWS * (4 * HOLD + 40) + 40) * 4);
    report_failure("watchdog expired, the rounds did not finish in time");
  end

endmodule

// ==== build.f ====
quiz_pkg.sv
answer_judge.sv
hp_tracker.sv
game_control.sv
quiz_top.sv
quiz_asserts.sv
tb_quiz.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the quiz duel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -f build.f \
  --top-module tb_quiz -Mdir obj_dir -o sim_quiz
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_quiz > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
